//--- Bender.yml
package:
  name: tcp_stream_tx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - tcp_stream_pkg.sv
      - tcp_stream_fifo.sv
      - tcp_seg_builder.sv
      - tcp_seg_serializer.sv
      - tcp_stream_tx.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tcp_stream_tx.sv

//--- tb_tcp_stream_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcp_stream_config.svh"

module tb_tcp_stream_tx;

  localparam int CYCLE_LIMIT = 4000;

  logic       tcp_cts_srv;
  logic       rst_n;
  logic [7:0] din;
  logic       vin;
  logic       snd;
  logic       cts;
  logic [7:0] dout;
  logic       vout;

  int err_mismatch;
  int err_other;
  int cycles;
  int cts_stalls;
  int cur_len;
  logic [31:0] lcg_state;
  logic [31:0] model_seq;

  // open segment of the model, then expected and received frames
  logic [7:0]  pend[$];
  logic [31:0] exp_seq[$];
  int          exp_len[$];
  logic [15:0] exp_csum[$];
  logic [7:0]  exp_pay[$];
  logic [7:0]  rx_bytes[$];
  int          rx_lens[$];

  tcp_stream_tx u_dut (
    .tcp_cts_srv (tcp_cts_srv),
    .rst_n       (rst_n),
    .din         (din),
    .vin         (vin),
    .snd         (snd),
    .cts         (cts),
    .dout        (dout),
    .vout        (vout)
  );

  always #2 tcp_cts_srv = ~tcp_cts_srv;

  // frame monitor, one burst of vout is one frame
  always @(posedge tcp_cts_srv) begin
    if (vout === 1'b1) begin
      rx_bytes.push_back(dout);
      cur_len = cur_len + 1;
    end else if (cur_len > 0) begin
      rx_lens.push_back(cur_len);
      cur_len = 0;
    end
  end

  always @(posedge tcp_cts_srv) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other + 1);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] got);
    $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expv, got);
    err_mismatch++;
  endtask

  // close the model segment, checksum pairs bytes big-endian
  task automatic close_segment();
    logic [15:0] s;
    logic [16:0] t;
    logic [15:0] word;
    int n;
    int i;
    n = pend.size();
    if (n == 0) begin
      return;
    end
    s = '0;
    for (i = 0; i < n; i += 2) begin
      word = {pend[i], (i + 1 < n) ? pend[i + 1] : 8'h00};
      t = {1'b0, s} + {1'b0, word};
      s = t[15:0] + {15'd0, t[16]};
    end
    exp_seq.push_back(model_seq);
    exp_len.push_back(n);
    exp_csum.push_back(~s);
    for (i = 0; i < n; i++) begin
      exp_pay.push_back(pend[i]);
    end
    model_seq = model_seq + n;
    pend.delete();
  endtask

  task automatic drive_byte(input logic [7:0] b, input logic s);
    @(negedge tcp_cts_srv);
    vin = 1'b0;
    snd = 1'b0;
    while (!cts) begin
      cts_stalls++;
      @(negedge tcp_cts_srv);
    end
    din = b;
    vin = 1'b1;
    snd = s;
    pend.push_back(b);
    if (pend.size() == `TCP_MSS || s) begin
      close_segment();
    end
  endtask

  task automatic pulse_snd();
    @(negedge tcp_cts_srv);
    vin = 1'b0;
    snd = 1'b1;
    close_segment();
  endtask

  // wait for the expected frames, then compare and look for extras
  task automatic check_frames(input int quiet);
    int waited;
    int n;
    int flen;
    int k;
    logic [31:0] eseq;
    logic [15:0] ecsum;
    logic [63:0] hdr;
    logic [7:0]  pb;
    logic [7:0]  rb;
    @(negedge tcp_cts_srv);
    vin = 1'b0;
    snd = 1'b0;
    waited = 0;
    while (rx_lens.size() < exp_len.size() && waited < 1000) begin
      @(negedge tcp_cts_srv);
      waited++;
    end
    repeat (quiet) @(negedge tcp_cts_srv);
    while (exp_len.size() > 0) begin
      n = exp_len.pop_front();
      eseq = exp_seq.pop_front();
      ecsum = exp_csum.pop_front();
      if (rx_lens.size() == 0) begin
        $display("missing frame at %0t: nothing came out for seq %0h", $time, eseq);
        err_other++;
        for (k = 0; k < n; k++) begin
          pb = exp_pay.pop_front();
        end
      end else begin
        flen = rx_lens.pop_front();
        hdr = '0;
        for (k = 0; k < `TCP_HDR_LEN && k < flen; k++) begin
          hdr = {hdr[55:0], rx_bytes.pop_front()};
        end
        if (hdr[63:32] !== eseq) report_mismatch("seq", eseq, hdr[63:32]);
        if (hdr[31:16] !== n[15:0]) report_mismatch("len", n, hdr[31:16]);
        if (hdr[15:0] !== ecsum) report_mismatch("csum", ecsum, hdr[15:0]);
        if (flen !== n + `TCP_HDR_LEN) report_mismatch("vout length", n + 8, flen);
        for (k = 0; k < n; k++) begin
          pb = exp_pay.pop_front();
          if (k < flen - `TCP_HDR_LEN) begin
            rb = rx_bytes.pop_front();
            if (rb !== pb) report_mismatch("dout", pb, rb);
          end
        end
        for (k = n; k < flen - `TCP_HDR_LEN; k++) begin
          rb = rx_bytes.pop_front();
        end
      end
    end
    while (rx_lens.size() > 0) begin
      flen = rx_lens.pop_front();
      $display("extra frame at %0t: unexpected burst of %0d bytes", $time, flen);
      err_other++;
      for (k = 0; k < flen; k++) begin
        rb = rx_bytes.pop_front();
      end
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic reset_state();
    rst_n = 1'b0;
    repeat (2) begin
      @(negedge tcp_cts_srv);
      if (vout !== 1'b0) report_mismatch("vout", 0, vout);
    end
    rst_n = 1'b1;
    @(negedge tcp_cts_srv);
    if (vout !== 1'b0) report_mismatch("vout", 0, vout);
    if (cts !== 1'b1) report_mismatch("cts", 1, cts);
  endtask

  task automatic single_byte_frame();
    drive_byte(next_rand(), 1'b1);
    check_frames(10);
    // nothing buffered, so no frame
    pulse_snd();
    check_frames(50);
  endtask

  task automatic stream_without_snd();
    repeat (40) drive_byte(next_rand(), 1'b0);
    pulse_snd();
    check_frames(10);
  endtask

  task automatic odd_length_checksums();
    int lens[3];
    int i;
    lens = '{3, 7, 15};
    for (i = 0; i < 3; i++) begin
      repeat (lens[i] - 1) drive_byte(next_rand(), 1'b0);
      drive_byte(next_rand(), 1'b1);
      check_frames(10);
    end
  endtask

  task automatic backpressure_run();
    cts_stalls = 0;
    repeat (200) drive_byte(next_rand(), 1'b0);
    pulse_snd();
    check_frames(10);
    if (cts_stalls == 0) begin
      $display("cts never fell while bytes were offered every cycle");
      err_other++;
    end
  endtask

  task automatic snd_on_full_segment();
    repeat (`TCP_MSS - 1) drive_byte(next_rand(), 1'b0);
    drive_byte(next_rand(), 1'b1);
    check_frames(20);
  endtask

  initial begin
    tcp_cts_srv = 1'b0;
    rst_n = 1'b0;
    din = 8'h00;
    vin = 1'b0;
    snd = 1'b0;
    err_mismatch = 0;
    err_other = 0;
    cycles = 0;
    cts_stalls = 0;
    cur_len = 0;
    lcg_state = 32'd22;
    model_seq = `TCP_ISN;

    reset_state();
    single_byte_frame();
    stream_without_snd();
    odd_length_checksums();
    backpressure_run();
    snd_on_full_segment();

    $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
    if (err_mismatch == 0 && err_other == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tcp_seg_builder.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcp_stream_config.svh"

module tcp_seg_builder (
  input  wire                         tcp_cts_srv,
  input  wire                         rst_n,
  input  wire  [7:0]                  din,
  input  wire                         vin,
  input  wire                         snd,
  input  wire                         pay_full,
  input  wire                         desc_full,
  output logic                        cts,
  output logic                        pay_push,
  output tcp_stream_pkg::byte_strobe_t pay_wdata,
  output logic                        desc_push,
  output tcp_stream_pkg::seg_desc_t    desc_wdata
);

  localparam int CW = $clog2(`TCP_MSS + 1);

  // open segment state
  logic [CW-1:0] count;
  logic [15:0]   sum;
  logic          lo_phase;
  logic [31:0]   next_seq;
  // snd seen while descriptor fifo was full
  logic          flush_pend;

  logic          accept;
  logic [CW-1:0] count_next;
  logic [15:0]   sum_add;
  logic [16:0]   sum_wide;
  logic [15:0]   sum_inc;
  logic [15:0]   sum_next;
  logic          close_req;
  logic          close;

  ////////////////////////////////////////
  // user side
  ////////////////////////////////////////

  // hold off while a close could not be stored
  assign cts    = !pay_full && !desc_full && !flush_pend;
  assign accept = vin && cts;

  assign pay_push  = accept;
  assign pay_wdata = '{data: din, valid: 1'b1};

  assign count_next = count + {{(CW-1){1'b0}}, accept};

  ////////////////////////////////////////
  // running checksum
  ////////////////////////////////////////

  // even bytes go high, odd bytes low
  assign sum_add  = lo_phase ? {8'h00, din} : {din, 8'h00};
  assign sum_wide = {1'b0, sum} + {1'b0, sum_add};
  // end-around carry cannot overflow again
  assign sum_inc  = sum_wide[15:0] + {15'd0, sum_wide[16]};
  assign sum_next = accept ? sum_inc : sum;

  ////////////////////////////////////////
  // segment close
  ////////////////////////////////////////

  assign close_req = (accept && (count == CW'(`TCP_MSS - 1))) ||
                     ((snd || flush_pend) && (count_next != '0));
  // a byte in this cycle implies desc fifo has room
  assign close     = close_req && !desc_full;

  assign desc_push  = close;
  assign desc_wdata = '{
    seq:  next_seq,
    len:  16'(count_next),
    csum: ~sum_next
  };

  always_ff @(posedge tcp_cts_srv) begin
    if (!rst_n) begin
      count      <= '0;
      sum        <= '0;
      lo_phase   <= 1'b0;
      next_seq   <= `TCP_ISN;
      flush_pend <= 1'b0;
    end else if (close) begin
      count      <= '0;
      sum        <= '0;
      lo_phase   <= 1'b0;
      next_seq   <= next_seq + 32'(count_next);
      flush_pend <= 1'b0;
    end else begin
      count <= count_next;
      sum   <= sum_next;
      if (accept) begin
        lo_phase <= ~lo_phase;
      end
      // only snd without room reaches here
      if (close_req) begin
        flush_pend <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // user protocol, vin only while clear to send
  a_vin_cts: assert property (
    @(posedge tcp_cts_srv) disable iff (!rst_n) vin |-> cts
  ) else $error("vin raised while cts low");

  // mss close must keep the open count bounded
  a_count_mss: assert property (
    @(posedge tcp_cts_srv) disable iff (!rst_n) count <= CW'(`TCP_MSS)
  ) else $error("segment count above mss");

endmodule

`default_nettype wire

//--- tcp_seg_serializer.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcp_stream_config.svh"

module tcp_seg_serializer (
  input  wire                          tcp_cts_srv,
  input  wire                          rst_n,
  input  tcp_stream_pkg::seg_desc_t    desc_rdata,
  input  wire                          desc_empty,
  input  tcp_stream_pkg::byte_strobe_t pay_rdata,
  input  wire                          pay_empty,
  output logic                         desc_pop,
  output logic                         pay_pop,
  output logic [7:0]                   dout,
  output logic                         vout
);

  localparam int HW = `TCP_HDR_LEN * 8;
  localparam int IW = $clog2(`TCP_HDR_LEN);

  typedef enum logic [1:0] {
    S_IDLE,
    S_HDR,
    S_PAY
  } state_t;

  state_t state;

  // header bytes go out msb first
  logic [HW-1:0] hdr_sr;
  logic [IW-1:0] hdr_idx;
  // payload bytes still to send
  logic [15:0]   pay_left;

  logic start;

  ////////////////////////////////////////
  // fifo side
  ////////////////////////////////////////

  assign start    = (state == S_IDLE) && !desc_empty;
  assign desc_pop = start;
  assign pay_pop  = (state == S_PAY);

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  assign vout = (state != S_IDLE);
  assign dout = (state == S_PAY) ? pay_rdata.data : hdr_sr[HW-1 -: 8];

  // header shift register
  always_ff @(posedge tcp_cts_srv) begin
    if (start) begin
      hdr_sr <= desc_rdata;
    end else if (state == S_HDR) begin
      hdr_sr <= {hdr_sr[HW-9:0], 8'h00};
    end
  end

  always_ff @(posedge tcp_cts_srv) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      hdr_idx  <= '0;
      pay_left <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state    <= S_HDR;
            hdr_idx  <= '0;
            pay_left <= desc_rdata.len;
          end
        end
        S_HDR: begin
          hdr_idx <= hdr_idx + 1'b1;
          if (hdr_idx == IW'(`TCP_HDR_LEN - 1)) begin
            // builder never closes an empty segment
            state <= (pay_left != '0) ? S_PAY : S_IDLE;
          end
        end
        S_PAY: begin
          pay_left <= pay_left - 1'b1;
          // back to idle gives the gap between frames
          if (pay_left == 16'd1) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // payload is pushed no later than its descriptor
  a_pay_ready: assert property (
    @(posedge tcp_cts_srv) disable iff (!rst_n)
      (state == S_PAY) |-> (!pay_empty && pay_rdata.valid)
  ) else $error("payload fifo underrun during frame");

endmodule

`default_nettype wire

//--- tcp_stream_config.svh
`ifndef TCP_STREAM_CONFIG_SVH
`define TCP_STREAM_CONFIG_SVH

// maximum payload bytes per segment
`define TCP_MSS 16

// payload fifo holds 2**6 bytes
`define TCP_PAYLOAD_AW 6

// descriptor fifo holds 2**2 closed segments
`define TCP_DESC_AW 2

// sequence number of the first byte after reset
`define TCP_ISN 32'h0000_1000

// seq, len and csum on the wire
`define TCP_HDR_LEN 8

`endif

//--- tcp_stream_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_stream_fifo #(
  parameter type elem_t = logic [7:0],
  parameter int  AW     = 4
) (
  input  wire   tcp_cts_srv,
  input  wire   rst_n,
  input  wire   push,
  input  wire   pop,
  input  elem_t wdata,
  output elem_t rdata,
  output logic  full,
  output logic  empty
);

  localparam int DEPTH = 2 ** AW;

  // storage
  elem_t mem [DEPTH];

  // pointers carry one extra wrap bit
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  ////////////////////////////////////////
  // pointer compare
  ////////////////////////////////////////

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // head is valid while not empty
  assign rdata = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge tcp_cts_srv) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= wdata;
    end
  end

  always_ff @(posedge tcp_cts_srv) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // producer must honour full or the element is dropped
  a_no_push_full: assert property (
    @(posedge tcp_cts_srv) disable iff (!rst_n) push |-> !full
  ) else $error("push into full fifo");

  // consumer must honour empty
  a_no_pop_empty: assert property (
    @(posedge tcp_cts_srv) disable iff (!rst_n) pop |-> !empty
  ) else $error("pop from empty fifo");

endmodule

`default_nettype wire

//--- tcp_stream_pkg.sv
`default_nettype none

package tcp_stream_pkg;

  ////////////////////////////////////////
  // stream element types
  ////////////////////////////////////////

  // one payload byte with its strobe
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } byte_strobe_t;

  // closed segment, field order matches the header byte order
  typedef struct packed {
    // sequence number of first payload byte
    logic [31:0] seq;
    // payload bytes in the segment
    logic [15:0] len;
    // inverted ones' complement sum of payload
    logic [15:0] csum;
  } seg_desc_t;

endpackage

`default_nettype wire

//--- tcp_stream_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcp_stream_config.svh"

module tcp_stream_tx (
  input  wire        tcp_cts_srv,
  input  wire        rst_n,
  input  wire  [7:0] din,
  input  wire        vin,
  input  wire        snd,
  output logic       cts,
  output logic [7:0] dout,
  output logic       vout
);

  import tcp_stream_pkg::*;

  ////////////////////////////////////////
  // payload path
  ////////////////////////////////////////

  logic         pay_push;
  logic         pay_pop;
  logic         pay_full;
  logic         pay_empty;
  byte_strobe_t pay_wdata;
  byte_strobe_t pay_rdata;

  // descriptor path
  logic      desc_push;
  logic      desc_pop;
  logic      desc_full;
  logic      desc_empty;
  seg_desc_t desc_wdata;
  seg_desc_t desc_rdata;

  tcp_seg_builder u_builder (
    .tcp_cts_srv (tcp_cts_srv),
    .rst_n       (rst_n),
    .din         (din),
    .vin         (vin),
    .snd         (snd),
    .pay_full    (pay_full),
    .desc_full   (desc_full),
    .cts         (cts),
    .pay_push    (pay_push),
    .pay_wdata   (pay_wdata),
    .desc_push   (desc_push),
    .desc_wdata  (desc_wdata)
  );

  tcp_stream_fifo #(
    .elem_t (byte_strobe_t),
    .AW     (`TCP_PAYLOAD_AW)
  ) u_pay_fifo (
    .tcp_cts_srv (tcp_cts_srv),
    .rst_n       (rst_n),
    .push        (pay_push),
    .pop         (pay_pop),
    .wdata       (pay_wdata),
    .rdata       (pay_rdata),
    .full        (pay_full),
    .empty       (pay_empty)
  );

  tcp_stream_fifo #(
    .elem_t (seg_desc_t),
    .AW     (`TCP_DESC_AW)
  ) u_desc_fifo (
    .tcp_cts_srv (tcp_cts_srv),
    .rst_n       (rst_n),
    .push        (desc_push),
    .pop         (desc_pop),
    .wdata       (desc_wdata),
    .rdata       (desc_rdata),
    .full        (desc_full),
    .empty       (desc_empty)
  );

  tcp_seg_serializer u_serializer (
    .tcp_cts_srv (tcp_cts_srv),
    .rst_n       (rst_n),
    .desc_rdata  (desc_rdata),
    .desc_empty  (desc_empty),
    .pay_rdata   (pay_rdata),
    .pay_empty   (pay_empty),
    .desc_pop    (desc_pop),
    .pay_pop     (pay_pop),
    .dout        (dout),
    .vout        (vout)
  );

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
tcp_stream_pkg.sv
tcp_stream_fifo.sv
tcp_seg_builder.sv
tcp_seg_serializer.sv
tcp_stream_tx.sv
tb_tcp_stream_tx.sv
